/* hdl/CorePkg.sv */
package CorePkg;

    // Datapath and register file sizing
    localparam int DataWidth = 16;
    localparam int RegAddrWidth = 4;
    localparam int RegCount = 1 << RegAddrWidth;

    // Tag space for operations that complete out of order
    localparam int TagWidth = 4;
    localparam int TagCount = 1 << TagWidth;

    // Bit positions in the one-hot functional unit enable
    localparam int FuCount = 5;
    localparam int FuAlu0 = 0;
    localparam int FuAlu1 = 1;
    localparam int FuComplex = 2;
    localparam int FuMemory = 3;
    localparam int FuBranch = 4;

    // Writeback source, code 00 is reserved
    localparam logic [1:0] WbPcPlusOne = 2'b01;
    localparam logic [1:0] WbAlu0 = 2'b10;
    localparam logic [1:0] WbAlu1 = 2'b11;

    // One instruction word, seen in register form or immediate form
    typedef union packed {
        struct packed {
            logic [3:0] majorOp;
            logic [3:0] regA;
            logic [3:0] minorOp;
            logic [3:0] regB;
        } regForm;
        struct packed {
            logic [3:0] majorOp;
            logic [1:0] regAHigh;
            logic [9:0] imm;
        } immForm;
    } InstrWord;

endpackage

/* hdl/InstructionDecoder.sv */
`timescale 1ns/10ps

module InstructionDecoder (
    input  logic                             rst,
    input  CorePkg::InstrWord                instrWord,
    input  logic                             instrValid,
    output logic                             tagRequest,
    output logic [CorePkg::FuCount-1:0]      unitEnable,
    output logic [1:0]                       wbSource,
    output logic [3:0]                       minorOp,
    output logic                             immediateEn,
    output logic                             upperImmediateEn,
    output logic [CorePkg::DataWidth-1:0]    immediate,
    output logic                             regAReadEn,
    output logic                             regAWriteEn,
    output logic [CorePkg::RegAddrWidth-1:0] regAAddr,
    output logic                             regBReadEn,
    output logic [CorePkg::RegAddrWidth-1:0] regBAddr,
    output logic                             branchStall
);

    logic [3:0] majorOp;
    logic       jumpAndLink;
    logic       highPairAddr;
    logic       stallOnRegA;

    assign majorOp = instrWord.regForm.majorOp;
    assign jumpAndLink = (majorOp[3:1] == 3'b100);
    assign highPairAddr = majorOp[3] && majorOp[0];

    // Link register override is held off while in reset
    always_comb begin
        if (jumpAndLink && !rst) begin
            regAAddr = '1;
        end else if (highPairAddr && !rst) begin
            regAAddr = {instrWord.immForm.regAHigh, 2'b00};
        end else begin
            regAAddr = instrWord.regForm.regA;
        end
    end

    assign regBAddr = instrWord.regForm.regB;
    assign minorOp = instrWord.regForm.minorOp;

    // Immediate shape picked by opcode bits 13:12
    always_comb begin
        immediate = '0;
        case (majorOp[1:0])
            2'b01: begin
                immediate[9:0] = instrWord.immForm.imm;
            end
            2'b10: begin
                immediate[CorePkg::DataWidth-1 -: 8] = instrWord.immForm.imm[7:0];
            end
            2'b11: begin
                immediate = '1;
                immediate[9:0] = instrWord.immForm.imm;
            end
            default: begin
                immediate[7:0] = instrWord.immForm.imm[7:0];
            end
        endcase
    end

    always_comb begin
        tagRequest = 1'b0;
        unitEnable = '0;
        wbSource = 2'b00;
        immediateEn = 1'b0;
        upperImmediateEn = 1'b0;
        regAReadEn = 1'b0;
        regAWriteEn = 1'b0;
        regBReadEn = 1'b0;
        stallOnRegA = 1'b0;
        if (instrValid) begin
            case (majorOp)
                4'b0000, 4'b0001: begin
                    unitEnable[majorOp[0] ? CorePkg::FuAlu1 : CorePkg::FuAlu0] = 1'b1;
                    wbSource = majorOp[0] ? CorePkg::WbAlu1 : CorePkg::WbAlu0;
                    regAReadEn = 1'b1;
                    regAWriteEn = 1'b1;
                    regBReadEn = 1'b1;
                end
                // Complex ALU and memory return results by tag
                4'b0010, 4'b0011: begin
                    unitEnable[majorOp[0] ? CorePkg::FuMemory : CorePkg::FuComplex] = 1'b1;
                    tagRequest = 1'b1;
                    regAReadEn = 1'b1;
                    regBReadEn = 1'b1;
                end
                4'b1000, 4'b1001: begin
                    unitEnable[CorePkg::FuBranch] = 1'b1;
                    wbSource = CorePkg::WbPcPlusOne;
                    regAWriteEn = 1'b1;
                    immediateEn = majorOp[0];
                    regBReadEn = !majorOp[0];
                end
                4'b1010, 4'b1011: begin
                    unitEnable[CorePkg::FuBranch] = 1'b1;
                    regAReadEn = 1'b1;
                    immediateEn = majorOp[0];
                    regBReadEn = !majorOp[0];
                    stallOnRegA = 1'b1;
                end
                // Immediates are finished locally, no unit
                4'b1100, 4'b1101, 4'b1110, 4'b1111: begin
                    immediateEn = 1'b1;
                    regAWriteEn = 1'b1;
                    upperImmediateEn = (majorOp[1:0] == 2'b10);
                    regAReadEn = (majorOp[1:0] == 2'b10);
                end
                default: begin
                    tagRequest = 1'b0;
                end
            endcase
        end
    end

    assign branchStall = stallOnRegA && (regAAddr != '0);

endmodule

/* hdl/IssueController.sv */
`timescale 1ns/10ps

module IssueController (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instrReq,
    output logic                        instrAck,
    output logic                        issueReq,
    input  logic                        issueAck,
    input  logic                        branchDone,
    input  logic                        tagRequest,
    input  logic [CorePkg::FuCount-1:0] unitEnable,
    input  logic                        regAWriteEn,
    input  logic                        branchStall,
    input  logic                        tagsFull,
    output logic                        capture,
    output logic                        tagTake,
    output logic                        localWrite
);

    enum logic [2:0] {Idle, Issue, WaitAckLow, Hold, Ack, WaitReqLow} state;

    logic localPending;
    logic stallPending;
    logic noUnit;

    assign noUnit = (unitEnable == '0);
    // Tag is consumed on the same edge that latches it
    assign tagTake = capture && tagRequest;
    assign localWrite = (state == Ack) && localPending;
    assign instrAck = (state == WaitReqLow);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            capture <= 1'b0;
            issueReq <= 1'b0;
            localPending <= 1'b0;
            stallPending <= 1'b0;
        end else begin
            capture <= 1'b0;
            if (branchDone) begin
                stallPending <= 1'b0;
            end
            case (state)
                Idle: begin
                    if (capture) begin
                        localPending <= noUnit && regAWriteEn;
                        stallPending <= branchStall;
                        if (noUnit) begin
                            state <= Ack;
                        end else begin
                            state <= Issue;
                        end
                    end else if (instrReq && !(tagRequest && tagsFull)) begin
                        capture <= 1'b1;
                    end
                end
                Issue: begin
                    if (!issueReq) begin
                        issueReq <= 1'b1;
                    end else if (issueAck) begin
                        issueReq <= 1'b0;
                        state <= WaitAckLow;
                    end
                end
                WaitAckLow: begin
                    if (!issueAck) begin
                        if (stallPending && !branchDone) begin
                            state <= Hold;
                        end else begin
                            state <= Ack;
                        end
                    end
                end
                // Fetch stays blocked until the branch resolves
                Hold: begin
                    if (branchDone) begin
                        state <= Ack;
                    end
                end
                Ack: begin
                    state <= WaitReqLow;
                end
                default: begin
                    if (!instrReq) begin
                        state <= Idle;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/TagCounter.sv */
`timescale 1ns/10ps

module TagCounter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tagTake,
    input  logic                         tagRelease,
    output logic [CorePkg::TagWidth-1:0] nextTag,
    output logic                         tagsFull
);

    // One extra bit so a full tag space can be told from an empty one
    logic [CorePkg::TagWidth:0] outstanding;

    assign tagsFull = (outstanding == (CorePkg::TagWidth + 1)'(CorePkg::TagCount));

    always_ff @(posedge clk) begin
        if (rst) begin
            nextTag <= '0;
            outstanding <= '0;
        end else begin
            if (tagTake) begin
                nextTag <= nextTag + 1'b1;
            end
            if (tagTake && !tagRelease) begin
                outstanding <= outstanding + 1'b1;
            end else if (tagRelease && !tagTake && outstanding != '0) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

endmodule

/* hdl/RegisterFile.sv */
`timescale 1ns/10ps

module RegisterFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [CorePkg::RegAddrWidth-1:0] regAAddr,
    input  logic [CorePkg::RegAddrWidth-1:0] regBAddr,
    output logic [CorePkg::DataWidth-1:0]    readA,
    output logic [CorePkg::DataWidth-1:0]    readB,
    input  logic                             wbEn,
    input  logic [CorePkg::RegAddrWidth-1:0] wbAddr,
    input  logic [CorePkg::DataWidth-1:0]    wbData,
    input  logic                             localWrite,
    input  logic [CorePkg::RegAddrWidth-1:0] localAddr,
    input  logic [CorePkg::DataWidth-1:0]    localData
);

    logic [CorePkg::DataWidth-1:0] regs [CorePkg::RegCount];

    // Reads are asynchronous and see the old value on a same-cycle write
    assign readA = regs[regAAddr];
    assign readB = regs[regBAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CorePkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wbEn) begin
                regs[wbAddr] <= wbData;
            end
            // Placed last so it overrides writeback on the same address
            if (localWrite) begin
                regs[localAddr] <= localData;
            end
        end
    end

endmodule

/* hdl/IssueRegister.sv */
`timescale 1ns/10ps

module IssueRegister (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             capture,
    input  CorePkg::InstrWord                instrWord,
    input  logic [CorePkg::FuCount-1:0]      unitEnable,
    input  logic [1:0]                       wbSource,
    input  logic                             immediateEn,
    input  logic                             upperImmediateEn,
    input  logic [CorePkg::DataWidth-1:0]    immediate,
    input  logic                             regAWriteEn,
    input  logic [CorePkg::RegAddrWidth-1:0] regAAddr,
    input  logic [CorePkg::DataWidth-1:0]    readA,
    input  logic [CorePkg::DataWidth-1:0]    readB,
    input  logic [CorePkg::TagWidth-1:0]     nextTag,
    input  logic                             tagRequest,
    output logic [CorePkg::FuCount-1:0]      issueUnitEnable,
    output logic [3:0]                       issueMinorOp,
    output logic [1:0]                       issueWbSource,
    output logic [CorePkg::DataWidth-1:0]    issueOperandA,
    output logic [CorePkg::DataWidth-1:0]    issueOperandB,
    output logic [CorePkg::DataWidth-1:0]    issueImmediate,
    output logic                             issueImmediateEn,
    output logic [CorePkg::RegAddrWidth-1:0] issueDestAddr,
    output logic                             issueDestWrite,
    output logic [CorePkg::TagWidth-1:0]     issueTag,
    output logic [CorePkg::DataWidth-1:0]    localResult,
    output logic [CorePkg::RegAddrWidth-1:0] localAddr
);

    localparam int Half = CorePkg::DataWidth / 2;

    logic upperImmediate;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueUnitEnable <= '0;
            issueImmediateEn <= 1'b0;
            issueDestWrite <= 1'b0;
            upperImmediate <= 1'b0;
        end else if (capture) begin
            issueUnitEnable <= unitEnable;
            issueImmediateEn <= immediateEn;
            issueDestWrite <= regAWriteEn;
            upperImmediate <= upperImmediateEn;
        end
    end

    // Operands held steady for the whole issue handshake
    always_ff @(posedge clk) begin
        if (capture) begin
            issueMinorOp <= instrWord.regForm.minorOp;
            issueWbSource <= wbSource;
            issueOperandA <= readA;
            issueOperandB <= readB;
            issueImmediate <= immediate;
            issueDestAddr <= regAAddr;
            issueTag <= tagRequest ? nextTag : '0;
        end
    end

    // Upper immediate keeps the low byte of register A
    assign localResult = upperImmediate ?
        {issueImmediate[CorePkg::DataWidth-1:Half], issueOperandA[Half-1:0]} :
        issueImmediate;
    assign localAddr = issueDestAddr;

endmodule

/* hdl/DecodeIssueUnit.sv */
`timescale 1ns/10ps

module DecodeIssueUnit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instrReq,
    output logic                             instrAck,
    input  logic [CorePkg::DataWidth-1:0]    instrData,
    output logic                             issueReq,
    input  logic                             issueAck,
    output logic [CorePkg::FuCount-1:0]      issueUnitEnable,
    output logic [3:0]                       issueMinorOp,
    output logic [1:0]                       issueWbSource,
    output logic [CorePkg::DataWidth-1:0]    issueOperandA,
    output logic [CorePkg::DataWidth-1:0]    issueOperandB,
    output logic [CorePkg::DataWidth-1:0]    issueImmediate,
    output logic                             issueImmediateEn,
    output logic [CorePkg::RegAddrWidth-1:0] issueDestAddr,
    output logic                             issueDestWrite,
    output logic [CorePkg::TagWidth-1:0]     issueTag,
    input  logic                             wbEn,
    input  logic [CorePkg::RegAddrWidth-1:0] wbAddr,
    input  logic [CorePkg::DataWidth-1:0]    wbData,
    input  logic                             tagRelease,
    input  logic                             branchDone
);

    logic                             tagRequest;
    logic [CorePkg::FuCount-1:0]      unitEnable;
    logic [1:0]                       wbSource;
    logic                             immediateEn;
    logic                             upperImmediateEn;
    logic [CorePkg::DataWidth-1:0]    immediate;
    logic                             regAWriteEn;
    logic [CorePkg::RegAddrWidth-1:0] regAAddr;
    logic [CorePkg::RegAddrWidth-1:0] regBAddr;
    logic                             branchStall;
    logic [CorePkg::DataWidth-1:0]    readA;
    logic [CorePkg::DataWidth-1:0]    readB;
    logic [CorePkg::TagWidth-1:0]     nextTag;
    logic                             tagsFull;
    logic                             capture;
    logic                             tagTake;
    logic                             localWrite;
    logic [CorePkg::DataWidth-1:0]    localResult;
    logic [CorePkg::RegAddrWidth-1:0] localAddr;

    // Decode is valid whenever fetch holds a request
    InstructionDecoder decoder (
        .rst(rst), .instrWord(instrData), .instrValid(instrReq),
        .tagRequest(tagRequest), .unitEnable(unitEnable), .wbSource(wbSource),
        .minorOp(), .immediateEn(immediateEn), .upperImmediateEn(upperImmediateEn),
        .immediate(immediate), .regAReadEn(), .regAWriteEn(regAWriteEn),
        .regAAddr(regAAddr), .regBReadEn(), .regBAddr(regBAddr),
        .branchStall(branchStall)
    );

    IssueController controller (
        .clk(clk), .rst(rst), .instrReq(instrReq), .instrAck(instrAck),
        .issueReq(issueReq), .issueAck(issueAck), .branchDone(branchDone),
        .tagRequest(tagRequest), .unitEnable(unitEnable), .regAWriteEn(regAWriteEn),
        .branchStall(branchStall), .tagsFull(tagsFull), .capture(capture),
        .tagTake(tagTake), .localWrite(localWrite)
    );

    TagCounter tags (
        .clk(clk), .rst(rst), .tagTake(tagTake), .tagRelease(tagRelease),
        .nextTag(nextTag), .tagsFull(tagsFull)
    );

    RegisterFile regFile (
        .clk(clk), .rst(rst), .regAAddr(regAAddr), .regBAddr(regBAddr),
        .readA(readA), .readB(readB), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .localWrite(localWrite), .localAddr(localAddr), .localData(localResult)
    );

    IssueRegister issueRegister (
        .clk(clk), .rst(rst), .capture(capture), .instrWord(instrData),
        .unitEnable(unitEnable), .wbSource(wbSource), .immediateEn(immediateEn),
        .upperImmediateEn(upperImmediateEn), .immediate(immediate),
        .regAWriteEn(regAWriteEn), .regAAddr(regAAddr), .readA(readA), .readB(readB),
        .nextTag(nextTag), .tagRequest(tagRequest),
        .issueUnitEnable(issueUnitEnable), .issueMinorOp(issueMinorOp),
        .issueWbSource(issueWbSource), .issueOperandA(issueOperandA),
        .issueOperandB(issueOperandB), .issueImmediate(issueImmediate),
        .issueImmediateEn(issueImmediateEn), .issueDestAddr(issueDestAddr),
        .issueDestWrite(issueDestWrite), .issueTag(issueTag),
        .localResult(localResult), .localAddr(localAddr)
    );

endmodule

/* bench/DecodeIssue_assert.sv */
`timescale 1ns/10ps

module DecodeIssueAssert (
    input logic clk,
    input logic rst,
    input logic instrReq,
    input logic instrAck,
    input logic issueReq,
    input logic issueAck,
    input logic capture,
    input logic tagRequest,
    input logic tagsFull
);

    // Set by a fetch request, cleared once the acknowledge is seen with it low
    logic reqSinceAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqSinceAck <= 1'b0;
        end else if (instrReq) begin
            reqSinceAck <= 1'b1;
        end else if (instrAck) begin
            reqSinceAck <= 1'b0;
        end
    end

    issueReqHeld: assert property (@(posedge clk) disable iff (rst)
        issueReq && !issueAck |=> issueReq)
        else $error("issueReq dropped before issueAck");

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        instrAck |-> reqSinceAck)
        else $error("instrAck raised with no fetch request since the last one");

    noCaptureWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(capture && tagRequest && tagsFull))
        else $error("capture fired for a tagged word with all tags outstanding");

endmodule

bind IssueController DecodeIssueAssert handshakeChecks (.*);

/* bench/DecodeIssueUnitTb.sv */
`timescale 1ns/10ps

module DecodeIssueUnitTb;

    localparam logic [1:0] KindIssue = 2'd0;
    localparam logic [1:0] KindLocal = 2'd1;
    localparam logic [1:0] KindDrop = 2'd2;
    localparam int RowCount = 19;
    localparam int TagFillOps = 14;
    localparam int SweepOps = 8;
    localparam int OpCount = RowCount + TagFillOps + SweepOps;
    localparam int AckLimit = 100;

    typedef struct packed {
        logic [15:0] word;
        logic        wbEn;
        logic [3:0]  wbAddr;
        logic [15:0] wbData;
        logic [1:0]  kind;
        logic        stall;
    } StimRow;

    // Word, writeback before it, expected kind, expected branch hold
    localparam StimRow Rows [RowCount] = '{
        '{16'h0152, 1'b1, 4'h2, 16'hBEEF, KindIssue, 1'b0},
        '{16'h1132, 1'b1, 4'h1, 16'h1234, KindIssue, 1'b0},
        '{16'h2371, 1'b1, 4'h3, 16'h00AA, KindIssue, 1'b0},
        '{16'h3213, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'hC5A7, 1'b0, 4'h0, 16'h0000, KindLocal, 1'b0},
        '{16'h0505, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'hDB6B, 1'b0, 4'h0, 16'h0000, KindLocal, 1'b0},
        '{16'hF605, 1'b0, 4'h0, 16'h0000, KindLocal, 1'b0},
        '{16'hE69C, 1'b1, 4'h6, 16'h5566, KindLocal, 1'b0},
        '{16'h1824, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'h06F6, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'h8301, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'h932A, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'hA203, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b1},
        '{16'hA003, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0},
        '{16'hB456, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b1},
        '{16'h4123, 1'b1, 4'h9, 16'h7777, KindDrop, 1'b0},
        '{16'h7FFF, 1'b0, 4'h0, 16'h0000, KindDrop, 1'b0},
        '{16'h2905, 1'b0, 4'h0, 16'h0000, KindIssue, 1'b0}
    };

    logic clk;
    logic rst;
    logic instrReq;
    logic instrAck;
    logic [CorePkg::DataWidth-1:0] instrData;
    logic issueReq;
    logic issueAck;
    logic [CorePkg::FuCount-1:0] issueUnitEnable;
    logic [3:0] issueMinorOp;
    logic [1:0] issueWbSource;
    logic [CorePkg::DataWidth-1:0] issueOperandA;
    logic [CorePkg::DataWidth-1:0] issueOperandB;
    logic [CorePkg::DataWidth-1:0] issueImmediate;
    logic issueImmediateEn;
    logic [CorePkg::RegAddrWidth-1:0] issueDestAddr;
    logic issueDestWrite;
    logic [CorePkg::TagWidth-1:0] issueTag;
    logic wbEn;
    logic [CorePkg::RegAddrWidth-1:0] wbAddr;
    logic [CorePkg::DataWidth-1:0] wbData;
    logic tagRelease;
    logic branchDone;

    // Reference state of the register file and the tag counter
    logic [15:0] modelRegs [16];
    logic [3:0] modelTag;
    int outstanding;
    int errorCount;
    int testCount;
    int failedTests;

    // Expected fields of the word under test
    logic [4:0] expUnit;
    logic [1:0] expWb;
    logic [3:0] expMinor;
    logic [3:0] expRegB;
    logic [3:0] expDest;
    logic [15:0] expImm;
    logic [15:0] expLocal;
    logic expImmEn;
    logic expDestWrite;
    logic expTagged;

    DecodeIssueUnit uut (
        .clk(clk), .rst(rst), .instrReq(instrReq), .instrAck(instrAck),
        .instrData(instrData), .issueReq(issueReq), .issueAck(issueAck),
        .issueUnitEnable(issueUnitEnable), .issueMinorOp(issueMinorOp),
        .issueWbSource(issueWbSource), .issueOperandA(issueOperandA),
        .issueOperandB(issueOperandB), .issueImmediate(issueImmediate),
        .issueImmediateEn(issueImmediateEn), .issueDestAddr(issueDestAddr),
        .issueDestWrite(issueDestWrite), .issueTag(issueTag), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .tagRelease(tagRelease), .branchDone(branchDone)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (OpCount * 200) @(posedge clk);
        $display("ERROR: watchdog expired before all tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("ERROR: %s", msg);
        errorCount++;
    endtask

    task automatic predict(input logic [15:0] word);
        logic [3:0] op;
        op = word[15:12];
        // Immediate shape from word bits 13:12
        case (op[1:0])
            2'b00: expImm = {8'h00, word[7:0]};
            2'b01: expImm = {6'b000000, word[9:0]};
            2'b10: expImm = {word[7:0], 8'h00};
            default: expImm = {6'b111111, word[9:0]};
        endcase
        if (op == 4'b1000 || op == 4'b1001) begin
            expDest = 4'd15;
        end else if (op[3] && op[0]) begin
            expDest = {word[11:10], 2'b00};
        end else begin
            expDest = word[11:8];
        end
        expMinor = word[7:4];
        expRegB = word[3:0];
        expUnit = '0;
        expWb = 2'b00;
        expTagged = 1'b0;
        expDestWrite = 1'b0;
        expImmEn = 1'b0;
        case (op)
            4'b0000, 4'b0001: begin
                expUnit[op[0] ? CorePkg::FuAlu1 : CorePkg::FuAlu0] = 1'b1;
                expWb = op[0] ? CorePkg::WbAlu1 : CorePkg::WbAlu0;
                expDestWrite = 1'b1;
            end
            4'b0010, 4'b0011: begin
                expUnit[op[0] ? CorePkg::FuMemory : CorePkg::FuComplex] = 1'b1;
                expTagged = 1'b1;
            end
            4'b1000, 4'b1001: begin
                expUnit[CorePkg::FuBranch] = 1'b1;
                expWb = CorePkg::WbPcPlusOne;
                expDestWrite = 1'b1;
                expImmEn = op[0];
            end
            4'b1010, 4'b1011: begin
                expUnit[CorePkg::FuBranch] = 1'b1;
                expImmEn = op[0];
            end
            default: begin
                expUnit = '0;
            end
        endcase
        // Upper immediate merges with the low byte already in register A
        expLocal = (op == 4'b1110) ? {expImm[15:8], modelRegs[expDest][7:0]} : expImm;
    endtask

    task automatic checkIssue();
        compareValue("issueUnitEnable", 32'(issueUnitEnable), 32'(expUnit));
        compareValue("issueWbSource", 32'(issueWbSource), 32'(expWb));
        compareValue("issueMinorOp", 32'(issueMinorOp), 32'(expMinor));
        compareValue("issueOperandA", 32'(issueOperandA), 32'(modelRegs[expDest]));
        compareValue("issueOperandB", 32'(issueOperandB), 32'(modelRegs[expRegB]));
        compareValue("issueImmediate", 32'(issueImmediate), 32'(expImm));
        compareValue("issueImmediateEn", 32'(issueImmediateEn), 32'(expImmEn));
        compareValue("issueDestAddr", 32'(issueDestAddr), 32'(expDest));
        compareValue("issueDestWrite", 32'(issueDestWrite), 32'(expDestWrite));
        compareValue("issueTag", 32'(issueTag), 32'(expTagged ? modelTag : 4'h0));
    endtask

    task automatic writeBack(input logic [3:0] addr, input logic [15:0] data);
        tick();
        wbEn = 1'b1;
        wbAddr = addr;
        wbData = data;
        tick();
        wbEn = 1'b0;
        modelRegs[addr] = data;
    endtask

    task automatic runOp(input logic [15:0] word, input logic [1:0] kind, input logic stall);
        int errorsBefore;
        int waitCycles;
        int ackDelay;
        errorsBefore = errorCount;
        predict(word);
        tick();
        instrData = word;
        instrReq = 1'b1;
        // Word waits for a release while all tags are in flight
        if (expTagged && outstanding == CorePkg::TagCount) begin
            repeat (8) begin
                tick();
                if (instrAck || issueReq) begin
                    reportProblem("tagged word taken while all tags were outstanding");
                end
            end
            tagRelease = 1'b1;
            tick();
            tagRelease = 1'b0;
            outstanding--;
        end
        if (kind == KindIssue) begin
            waitCycles = 0;
            while (!issueReq && waitCycles < AckLimit) begin
                tick();
                waitCycles++;
            end
            if (!issueReq) begin
                reportProblem("issueReq never rose for a word that needs a unit");
            end else begin
                checkIssue();
                ackDelay = int'($urandom_range(4));
                // Fetch stays unacknowledged until the execution side answers
                repeat (ackDelay) begin
                    tick();
                    if (instrAck) begin
                        reportProblem("instrAck rose before issueAck");
                    end
                end
                checkIssue();
                issueAck = 1'b1;
                while (issueReq) tick();
                issueAck = 1'b0;
                if (expTagged) begin
                    modelTag = modelTag + 4'd1;
                    outstanding++;
                end
                if (stall) begin
                    repeat (6) begin
                        tick();
                        if (instrAck) begin
                            reportProblem("instrAck rose before branchDone");
                        end
                    end
                    branchDone = 1'b1;
                    tick();
                    branchDone = 1'b0;
                end
            end
        end
        waitCycles = 0;
        while (!instrAck && waitCycles < AckLimit) begin
            tick();
            waitCycles++;
            if (issueReq && kind != KindIssue) begin
                reportProblem("issueReq raised for a word with no unit");
            end
        end
        if (!instrAck) begin
            reportProblem("instrAck never rose");
        end
        if (kind == KindLocal) begin
            modelRegs[expDest] = expLocal;
        end
        instrReq = 1'b0;
        while (instrAck) tick();
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d word %h: ok", testCount, word);
        end else begin
            failedTests++;
            $display("test %0d word %h: mismatch", testCount, word);
        end
    endtask

    initial begin
        void'($urandom(60355));
        rst = 1'b1;
        instrReq = 1'b0;
        instrData = '0;
        issueAck = 1'b0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        tagRelease = 1'b0;
        branchDone = 1'b0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        modelTag = 4'h0;
        outstanding = 0;
        for (int r = 0; r < 16; r++) begin
            modelRegs[r] = 16'h0000;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        compareValue("instrAck", 32'(instrAck), 32'h0);
        compareValue("issueReq", 32'(issueReq), 32'h0);
        for (int i = 0; i < RowCount; i++) begin
            if (Rows[i].wbEn) begin
                writeBack(Rows[i].wbAddr, Rows[i].wbData);
            end
            runOp(Rows[i].word, Rows[i].kind, Rows[i].stall);
        end
        // Memory ops fill the tag space and one more has to wait
        for (int i = 0; i < TagFillOps; i++) begin
            runOp({4'b0011, 4'(i), 4'h0, 4'(i)}, KindIssue, 1'b0);
        end
        // Read back every register through ALU operands
        for (int r = 0; r < SweepOps; r++) begin
            runOp({4'b0000, 4'(2 * r), 4'h0, 4'(2 * r + 1)}, KindIssue, 1'b0);
        end
        $display("tests %0d, failed %0d, mismatches %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/CorePkg.sv
hdl/InstructionDecoder.sv
hdl/IssueController.sv
hdl/TagCounter.sv
hdl/RegisterFile.sv
hdl/IssueRegister.sv
hdl/DecodeIssueUnit.sv
bench/DecodeIssue_assert.sv
bench/DecodeIssueUnitTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode and issue testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module DecodeIssueUnitTb -f filelist.f -o simDecodeIssue
./obj_dir/simDecodeIssue > sim.log 2>&1 || true
cat sim.log
if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
